// ==== verilog/noc_flit_pkg.sv ====
package noc_flit_pkg;

	// Field widths of a single-flit packet
	localparam int COORD_WIDTH = 4;
	localparam int PAYLOAD_WIDTH = 12;
	localparam int FLIT_WIDTH = COORD_WIDTH + PAYLOAD_WIDTH;

	// Destination field sits right above the payload
	localparam int DEST_LSB = PAYLOAD_WIDTH;

	// Column coordinate, also the flit destination field
	typedef logic [COORD_WIDTH-1:0] coord_t;

	// Opaque payload, never looked at by the routers
	typedef logic [PAYLOAD_WIDTH-1:0] payload_t;

	// Whole flit as seen on a channel
	typedef logic [FLIT_WIDTH-1:0] flit_t;

	// Destination column of a flit
	function automatic coord_t flit_dest(input flit_t flit);
		return flit[DEST_LSB +: COORD_WIDTH];
	endfunction

	// Pack a destination and a payload into one flit
	function automatic flit_t make_flit(input coord_t dest, input payload_t payload);
		return {dest, payload};
	endfunction

endpackage

// ==== verilog/noc_flow_pkg.sv ====
package noc_flow_pkg;

	import noc_flit_pkg::*;

	// Column of this router in the line
	localparam coord_t NODE_X = coord_t'(4);

	// Input FIFO depth, equal to the credits an upstream sender starts with
	localparam int BUF_DEPTH = 4;

	// FIFO pointer width
	localparam int PTR_WIDTH = $clog2(BUF_DEPTH);

	// Counts 0 up to BUF_DEPTH inclusive
	typedef logic [$clog2(BUF_DEPTH+1)-1:0] credit_cnt_t;

	// Read and write pointer of an input FIFO
	typedef logic [PTR_WIDTH-1:0] buf_ptr_t;

	// Output direction of a flit
	typedef enum logic {
		PORT_XNEG = 1'b0,
		PORT_XPOS = 1'b1
	} port_t;

endpackage

// ==== verilog/switch_req_if.sv ====
`timescale 1ns/100ps

// Request from one input port to the switch allocator, and grant back
interface switch_req_if
	import noc_flit_pkg::*, noc_flow_pkg::*;
();

	// FIFO holds at least one flit
	logic req;

	// Head of the FIFO
	flit_t flit;

	// Output the head flit is routed to
	port_t dest_port;

	// Head wins the switch this cycle, popped at next edge
	logic grant;

	// Input port side
	modport requester (
		output req,
		output flit,
		output dest_port,
		input grant
	);

	// Allocator side
	modport arbiter (
		input req,
		input flit,
		input dest_port,
		output grant
	);

endinterface

// ==== verilog/input_port.sv ====
`timescale 1ns/100ps

// One edge input: flit FIFO, route compute and credit return
module input_port
	import noc_flit_pkg::*, noc_flow_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input flit_t in_flit,
	output logic credit_out,
	switch_req_if.requester req_bus
);

	// FIFO storage, no reset on the data
	flit_t fifo_mem [BUF_DEPTH];

	// Circular pointers and occupancy
	buf_ptr_t wr_ptr;
	buf_ptr_t rd_ptr;
	credit_cnt_t fill_cnt;

	logic fifo_empty;
	logic fifo_full;
	logic push;
	logic pop;
	flit_t head_flit;

	assign fifo_empty = (fill_cnt == '0);
	assign fifo_full = (fill_cnt == credit_cnt_t'(BUF_DEPTH));

	// Write into a full FIFO is lost; upstream credits rule this out
	assign push = in_valid && !fifo_full;

	// Grant only comes with a valid head
	assign pop = req_bus.grant;

	// Pointer step with wrap at BUF_DEPTH
	function automatic buf_ptr_t ptr_next(input buf_ptr_t ptr);
		if (ptr == buf_ptr_t'(BUF_DEPTH - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	// Storage write
	always_ff @(posedge clk)
	begin
		if (push)
			fifo_mem[wr_ptr] <= in_flit;
	end

	// Pointers and fill count
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill_cnt <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			// Simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10: fill_cnt <= fill_cnt + 1'b1;
				2'b01: fill_cnt <= fill_cnt - 1'b1;
				default: fill_cnt <= fill_cnt;
			endcase
		end
	end

	// One credit back upstream per popped flit, one cycle after the pop
	always_ff @(posedge clk)
	begin
		if (reset)
			credit_out <= 1'b0;
		else
			credit_out <= pop;
	end

	assign head_flit = fifo_mem[rd_ptr];

	// Present the head to the allocator
	assign req_bus.req = !fifo_empty;
	assign req_bus.flit = head_flit;

	// West of this column goes out xneg, everything else xpos
	assign req_bus.dest_port = (flit_dest(head_flit) < NODE_X) ? PORT_XNEG : PORT_XPOS;

endmodule

// ==== verilog/switch_allocator.sv ====
`timescale 1ns/100ps

// Round-robin allocation per output and the 2x2 crossbar
module switch_allocator
	import noc_flit_pkg::*, noc_flow_pkg::*;
(
	input logic clk,
	input logic reset,
	switch_req_if.arbiter xneg_req,
	switch_req_if.arbiter xpos_req,
	input logic xneg_has_credit,
	input logic xpos_has_credit,
	output logic xneg_send,
	output logic xpos_send,
	output flit_t xneg_send_flit,
	output flit_t xpos_send_flit
);

	// Bit 0 is the xneg input, bit 1 the xpos input
	logic [1:0] neg_out_req;
	logic [1:0] pos_out_req;
	logic [1:0] neg_out_gnt;
	logic [1:0] pos_out_gnt;

	// High when an output favours the xpos input on contention
	logic neg_out_prio_pos;
	logic pos_out_prio_pos;

	// Grant for one output; nothing goes out without a credit
	function automatic logic [1:0] arbitrate(
		input logic [1:0] req,
		input logic prio_pos,
		input logic has_credit
	);
		logic [1:0] gnt;
		gnt = 2'b00;
		if (has_credit)
		begin
			if (req == 2'b11)
				gnt = prio_pos ? 2'b10 : 2'b01;
			else
				gnt = req;
		end
		return gnt;
	endfunction

	// Sort requests by the output they head for
	assign neg_out_req = {
		xpos_req.req && (xpos_req.dest_port == PORT_XNEG),
		xneg_req.req && (xneg_req.dest_port == PORT_XNEG)
	};
	assign pos_out_req = {
		xpos_req.req && (xpos_req.dest_port == PORT_XPOS),
		xneg_req.req && (xneg_req.dest_port == PORT_XPOS)
	};

	assign neg_out_gnt = arbitrate(neg_out_req, neg_out_prio_pos, xneg_has_credit);
	assign pos_out_gnt = arbitrate(pos_out_req, pos_out_prio_pos, xpos_has_credit);

	// An input heads for one output only, so at most one term is set
	assign xneg_req.grant = neg_out_gnt[0] | pos_out_gnt[0];
	assign xpos_req.grant = neg_out_gnt[1] | pos_out_gnt[1];

	// Priority moves to the loser after a contended grant
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			neg_out_prio_pos <= 1'b0;
			pos_out_prio_pos <= 1'b0;
		end
		else
		begin
			if ((neg_out_req == 2'b11) && (neg_out_gnt != 2'b00))
				neg_out_prio_pos <= neg_out_gnt[0];
			if ((pos_out_req == 2'b11) && (pos_out_gnt != 2'b00))
				pos_out_prio_pos <= pos_out_gnt[0];
		end
	end

	// Crossbar
	assign xneg_send = |neg_out_gnt;
	assign xpos_send = |pos_out_gnt;
	assign xneg_send_flit = neg_out_gnt[1] ? xpos_req.flit : xneg_req.flit;
	assign xpos_send_flit = pos_out_gnt[1] ? xpos_req.flit : xneg_req.flit;

endmodule

// ==== verilog/output_port.sv ====
`timescale 1ns/100ps

// One edge output: channel register and downstream credit counter
module output_port
	import noc_flit_pkg::*, noc_flow_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic send,
	input flit_t send_flit,
	input logic credit_in,
	output logic has_credit,
	output logic out_valid,
	output flit_t out_flit
);

	// Free slots in the downstream input FIFO
	credit_cnt_t credit_cnt;

	// Spend on send, refill on credit pulse
	always_ff @(posedge clk)
	begin
		if (reset)
			credit_cnt <= credit_cnt_t'(BUF_DEPTH);
		else
		begin
			case ({send, credit_in})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				// Both at once cancel out
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	assign has_credit = (credit_cnt != '0);

	// Valid lasts exactly one cycle per send
	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= send;
	end

	// Flit register, only loaded with a send
	always_ff @(posedge clk)
	begin
		if (send)
			out_flit <= send_flit;
	end

endmodule

// ==== verilog/network_core.sv ====
`timescale 1ns/100ps

// Two-port router node, xneg on the west edge and xpos on the east
module network_core
	import noc_flit_pkg::*;
(
	input logic clk,
	input logic reset,

	// West edge
	input logic xneg_in_valid,
	input logic [FLIT_WIDTH-1:0] xneg_in_flit,
	output logic xneg_credit_out,
	output logic xneg_out_valid,
	output logic [FLIT_WIDTH-1:0] xneg_out_flit,
	input logic xneg_credit_in,

	// East edge
	input logic xpos_in_valid,
	input logic [FLIT_WIDTH-1:0] xpos_in_flit,
	output logic xpos_credit_out,
	output logic xpos_out_valid,
	output logic [FLIT_WIDTH-1:0] xpos_out_flit,
	input logic xpos_credit_in
);

	// Allocator to output port
	logic xneg_send;
	logic xpos_send;
	flit_t xneg_send_flit;
	flit_t xpos_send_flit;
	logic xneg_has_credit;
	logic xpos_has_credit;

	// Input port to allocator, one per edge
	switch_req_if xneg_req ();
	switch_req_if xpos_req ();

	// Input side
	input_port u_xneg_in (
		.clk (clk),
		.reset (reset),
		.in_valid (xneg_in_valid),
		.in_flit (xneg_in_flit),
		.credit_out (xneg_credit_out),
		.req_bus (xneg_req.requester)
	);

	input_port u_xpos_in (
		.clk (clk),
		.reset (reset),
		.in_valid (xpos_in_valid),
		.in_flit (xpos_in_flit),
		.credit_out (xpos_credit_out),
		.req_bus (xpos_req.requester)
	);

	// Arbitration and crossbar
	switch_allocator u_alloc (
		.clk (clk),
		.reset (reset),
		.xneg_req (xneg_req.arbiter),
		.xpos_req (xpos_req.arbiter),
		.xneg_has_credit (xneg_has_credit),
		.xpos_has_credit (xpos_has_credit),
		.xneg_send (xneg_send),
		.xpos_send (xpos_send),
		.xneg_send_flit (xneg_send_flit),
		.xpos_send_flit (xpos_send_flit)
	);

	// Output side
	output_port u_xneg_out (
		.clk (clk),
		.reset (reset),
		.send (xneg_send),
		.send_flit (xneg_send_flit),
		.credit_in (xneg_credit_in),
		.has_credit (xneg_has_credit),
		.out_valid (xneg_out_valid),
		.out_flit (xneg_out_flit)
	);

	output_port u_xpos_out (
		.clk (clk),
		.reset (reset),
		.send (xpos_send),
		.send_flit (xpos_send_flit),
		.credit_in (xpos_credit_in),
		.has_credit (xpos_has_credit),
		.out_valid (xpos_out_valid),
		.out_flit (xpos_out_flit)
	);

endmodule

// ==== verif/network_core_tb.sv ====
`timescale 1ns/100ps

// Testbench for the two-port router node
module network_core_tb
	import noc_flit_pkg::*, noc_flow_pkg::*;
();

	// Flits sent over the whole run bound the cycle limit
	localparam int N_RAND = 40;
	localparam int TOTAL_FLITS = 8 + 4 + 12 + 8 + 16 + 2 * N_RAND;
	localparam int CYCLE_LIMIT = 20 * TOTAL_FLITS + 200;

	logic clk;
	logic reset;

	// Index 0 is the xneg edge, index 1 the xpos edge
	logic in_valid [2];
	flit_t in_flit [2];
	logic credit_out [2];
	logic out_valid [2];
	flit_t out_flit [2];
	logic credit_in [2];

	// Upstream side: flits sent and credits seen per input edge
	int up_sent [2];
	int up_ret [2];
	int seq [2];

	// Downstream side: flits seen, credits driven, credits landed in the DUT
	int dn_got [2];
	int dn_ret [2];
	int dn_ret_seen [2];
	logic hold [2];
	logic rand_ret;

	// Expected flits per output and source, index output * 2 + source
	flit_t sb_q [4][$];
	logic sb_ok [2];
	logic sb_extra [2];
	flit_t sb_exp [2];
	flit_t sb_got [2];

	// Check enables
	logic lat_en;
	logic alt_en;
	logic alt_have_prev;
	logic alt_last_src;

	string test_name;
	int err_cnt;
	int test_errs;
	int pass_tests;
	int fail_tests;
	int cycles;

	network_core uut (
		.clk (clk),
		.reset (reset),
		.xneg_in_valid (in_valid[0]),
		.xneg_in_flit (in_flit[0]),
		.xneg_credit_out (credit_out[0]),
		.xneg_out_valid (out_valid[0]),
		.xneg_out_flit (out_flit[0]),
		.xneg_credit_in (credit_in[0]),
		.xpos_in_valid (in_valid[1]),
		.xpos_in_flit (in_flit[1]),
		.xpos_credit_out (credit_out[1]),
		.xpos_out_valid (out_valid[1]),
		.xpos_out_flit (out_flit[1]),
		.xpos_credit_in (credit_in[1])
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Destinations west of this column leave through xneg
	function automatic int route_of(input flit_t flit);
		return (flit[FLIT_WIDTH-1 -: COORD_WIDTH] < NODE_X) ? 0 : 1;
	endfunction

	function automatic int up_credits(input int src);
		return BUF_DEPTH - up_sent[src] + up_ret[src];
	endfunction

	function automatic int outstanding();
		return sb_q[0].size() + sb_q[1].size() + sb_q[2].size() + sb_q[3].size();
	endfunction

	// Match an arriving flit against the queue of its source
	task automatic check_arrival(input int p, input flit_t flit);
		int q;
		q = p * 2 + flit[PAYLOAD_WIDTH-1];
		if (sb_q[q].size() == 0)
			sb_extra[p] = 1'b1;
		else
		begin
			sb_exp[p] = sb_q[q].pop_front();
			sb_got[p] = flit;
			sb_ok[p] = (sb_exp[p] == flit);
		end
	endtask

	// Sample the DUT at each edge and keep the models current
	always @(posedge clk)
	begin
		for (int p = 0; p < 2; p++)
		begin
			sb_ok[p] = 1'b1;
			sb_extra[p] = 1'b0;
			if (!reset)
			begin
				if (credit_out[p])
					up_ret[p]++;
				if (credit_in[p])
					dn_ret_seen[p]++;
				if (out_valid[p])
				begin
					dn_got[p]++;
					check_arrival(p, out_flit[p]);
				end
			end
		end
		if (!reset && out_valid[1])
		begin
			alt_last_src = out_flit[1][PAYLOAD_WIDTH-1];
			alt_have_prev = 1'b1;
		end
	end

	// Downstream receiver hands back one credit per cycle unless held
	always @(posedge clk)
	begin
		#1;
		for (int o = 0; o < 2; o++)
		begin
			credit_in[o] = 1'b0;
			if (!reset && !hold[o] && (dn_got[o] > dn_ret[o]))
			begin
				// Random mode skips about half the cycles
				if (!rand_ret || ($urandom % 2 == 1))
				begin
					credit_in[o] = 1'b1;
					dn_ret[o]++;
				end
			end
		end
	end

	// Both channels quiet in the first cycle after reset
	assert property (@(posedge clk) $fell(reset) |->
		!(out_valid[0] || out_valid[1] || credit_out[0] || credit_out[1]))
	else
	begin
		$display("error %s: expected outputs 0000, actual %b%b%b%b", test_name,
			$sampled(out_valid[0]), $sampled(out_valid[1]),
			$sampled(credit_out[0]), $sampled(credit_out[1]));
		err_cnt++;
	end

	// Contended stream alternates between the two sources
	assert property (@(posedge clk) disable iff (reset)
		alt_en && alt_have_prev && out_valid[1] |->
		(out_flit[1][PAYLOAD_WIDTH-1] != alt_last_src))
	else
	begin
		$display("error %s: expected source %0d, actual %0d", test_name,
			!$sampled(alt_last_src), $sampled(out_flit[1][PAYLOAD_WIDTH-1]));
		err_cnt++;
	end

	for (genvar p = 0; p < 2; p++)
	begin : g_port
		// Send decided on the credits the DUT had counted by then
		assert property (@(posedge clk) disable iff (reset)
			out_valid[p] |-> (BUF_DEPTH - dn_got[p] + $past(dn_ret_seen[p])) > 0)
		else
		begin
			$display("error %s: output %0d sent with no downstream credit", test_name, p);
			err_cnt++;
		end

		assert property (@(posedge clk) sb_ok[p])
		else
		begin
			$display("error %s: output %0d expected %h, actual %h", test_name, p,
				$sampled(sb_exp[p]), $sampled(sb_got[p]));
			err_cnt++;
		end

		assert property (@(posedge clk) !sb_extra[p])
		else
		begin
			$display("error %s: output %0d sent a flit that was never expected",
				test_name, p);
			err_cnt++;
		end

		// Never more credit pulses than accepted flits
		assert property (@(posedge clk) up_ret[p] <= up_sent[p])
		else
		begin
			$display("error %s: input %0d returned more credits than flits accepted",
				test_name, p);
			err_cnt++;
		end

		// Uncontended flit and its credit both show two edges after acceptance
		assert property (@(posedge clk) disable iff (reset)
			lat_en && in_valid[p] |-> ##2 credit_out[p]
			&& out_valid[route_of($past(in_flit[p], 2))]
			&& (out_flit[route_of($past(in_flit[p], 2))] == $past(in_flit[p], 2)))
		else
		begin
			$display("error %s: input %0d flit missed its route or two-edge latency",
				test_name, p);
			err_cnt++;
		end
	end

	// Wait for an upstream credit, then drive one flit for one cycle
	task automatic send_one(input int src, input int dest);
		flit_t flit;
		while (up_credits(src) <= 0)
		begin
			@(posedge clk);
			#1;
		end
		// Payload carries the source edge in bit 11 and a sequence number
		flit = {coord_t'(dest), 1'(src), 11'(seq[src])};
		seq[src]++;
		sb_q[route_of(flit) * 2 + src].push_back(flit);
		up_sent[src]++;
		in_valid[src] = 1'b1;
		in_flit[src] = flit;
		@(posedge clk);
		#1;
		in_valid[src] = 1'b0;
	endtask

	// Mode 0 fixed destination, 1 random destination, 2 random with gaps
	task automatic stream(input int src, input int n, input int dest, input int mode);
		int d;
		for (int k = 0; k < n; k++)
		begin
			d = (mode == 0) ? dest : int'($urandom % 16);
			if ((mode == 2) && ($urandom % 4 == 0))
			begin
				@(posedge clk);
				#1;
			end
			send_one(src, d);
		end
	endtask

	task automatic wait_arrivals(input int o, input int target);
		while (dn_got[o] < target)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// All flits delivered and all downstream credits landed
	task automatic wait_idle();
		while ((outstanding() != 0) || (dn_got[0] != dn_ret_seen[0])
			|| (dn_got[1] != dn_ret_seen[1]))
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic expect_equal(input string what, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("error %s %s: expected %0d, actual %0d", test_name, what,
				expected, actual);
			err_cnt++;
		end
	endtask

	task automatic expect_credits_home();
		expect_equal("xneg upstream credits", BUF_DEPTH, up_credits(0));
		expect_equal("xpos upstream credits", BUF_DEPTH, up_credits(1));
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt == test_errs)
		begin
			$display("pass %s", test_name);
			pass_tests++;
		end
		else
		begin
			$display("fail %s with %0d errors", test_name, err_cnt - test_errs);
			fail_tests++;
		end
	endtask

	// Run limit
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		int base;
		void'($urandom(32'h22559528));
		reset = 1'b1;
		for (int p = 0; p < 2; p++)
		begin
			in_valid[p] = 1'b0;
			in_flit[p] = '0;
			credit_in[p] = 1'b0;
			hold[p] = 1'b0;
			sb_ok[p] = 1'b1;
			sb_extra[p] = 1'b0;
		end
		rand_ret = 1'b0;
		lat_en = 1'b0;
		alt_en = 1'b0;
		alt_have_prev = 1'b0;
		alt_last_src = 1'b0;
		test_name = "reset";
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// Reset credits alone carry four flits per output
		begin_test("reset_state");
		hold[0] = 1'b1;
		hold[1] = 1'b1;
		for (int s = 0; s < 2; s++)
		begin
			send_one(s, 1);
			send_one(s, 12);
			send_one(s, 3);
			send_one(s, 4);
		end
		wait_arrivals(0, BUF_DEPTH);
		wait_arrivals(1, BUF_DEPTH);
		hold[0] = 1'b0;
		hold[1] = 1'b0;
		wait_idle();
		end_test();

		// One flit at a time, both sides of the node column, 4 is the boundary
		begin_test("routing_latency");
		lat_en = 1'b1;
		for (int s = 0; s < 2; s++)
		begin
			send_one(s, 3);
			wait_idle();
			send_one(s, 4);
			wait_idle();
		end
		lat_en = 1'b0;
		end_test();

		begin_test("credit_return");
		fork
			stream(0, 6, 0, 1);
			stream(1, 6, 0, 1);
		join
		wait_idle();
		expect_credits_home();
		end_test();

		// Hold xpos credits, twice a FIFO's worth from xneg
		begin_test("back_pressure");
		hold[1] = 1'b1;
		base = dn_got[1];
		stream(0, 2 * BUF_DEPTH, 9, 0);
		wait_arrivals(1, base + BUF_DEPTH);
		repeat (20) @(posedge clk);
		#1;
		expect_equal("flits out while held", BUF_DEPTH, dn_got[1] - base);
		expect_equal("xneg credits while held", 0, up_credits(0));
		hold[1] = 1'b0;
		wait_idle();
		expect_equal("flits out after release", 2 * BUF_DEPTH, dn_got[1] - base);
		end_test();

		// Both edges stream into xpos
		begin_test("contention");
		alt_have_prev = 1'b0;
		alt_en = 1'b1;
		fork
			stream(0, 8, 10, 0);
			stream(1, 8, 10, 0);
		join
		wait_idle();
		alt_en = 1'b0;
		end_test();

		begin_test("random_traffic");
		rand_ret = 1'b1;
		fork
			stream(0, N_RAND, 0, 2);
			stream(1, N_RAND, 0, 2);
		join
		wait_idle();
		rand_ret = 1'b0;
		expect_credits_home();
		end_test();

		$display("tests passed: %0d, failed: %0d", pass_tests, fail_tests);
		if ((fail_tests == 0) && (err_cnt == 0))
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/noc_flit_pkg.sv
verilog/noc_flow_pkg.sv
verilog/switch_req_if.sv
verilog/input_port.sv
verilog/switch_allocator.sv
verilog/output_port.sv
verilog/network_core.sv
verif/network_core_tb.sv

// ==== Bender.yml ====
package:
  name: network_core

dependencies: {}

sources:
  - verilog/noc_flit_pkg.sv
  - verilog/noc_flow_pkg.sv
  - verilog/switch_req_if.sv
  - verilog/input_port.sv
  - verilog/switch_allocator.sv
  - verilog/output_port.sv
  - verilog/network_core.sv
  - target: test
    files:
      - verif/network_core_tb.sv
